// File: hw/rename_cfg_pkg.sv
/*
 * sizing of the architectural and physical register spaces
 * and the number of physical registers free out of reset
 */

package rename_cfg_pkg;

	// architectural register space, 16 regs
	localparam int ARCH_REG_BITS = 4;
	localparam int ARCH_REG_COUNT = 1 << ARCH_REG_BITS;

	// physical register space, 64 regs
	localparam int PHYS_REG_BITS = 6;
	localparam int PHYS_REG_COUNT = 1 << PHYS_REG_BITS;

	// regs 0..ARCH_REG_COUNT-1 start mapped 1:1 to the arch regs,
	// everything above them sits in the free list after reset
	localparam int FREE_PRELOAD_COUNT = PHYS_REG_COUNT - ARCH_REG_COUNT;

endpackage : rename_cfg_pkg

// File: hw/uop_pkg.sv
/*
 * micro-op opcode enum, instruction field positions
 * and the destination-write predicate
 */

package uop_pkg;

	// 4-bit opcodes, anything else decodes as nop
	typedef enum logic [3:0] {
		OP_NOP    = 4'h0,
		OP_ALU    = 4'h1,
		OP_LOAD   = 4'h2,
		OP_STORE  = 4'h3,
		OP_BRANCH = 4'h4
	} op_t;

	// instruction word layout, low 16 bits unused by rename
	localparam int OPC_MSB  = 31;
	localparam int OPC_LSB  = 28;
	localparam int DST_MSB  = 27;
	localparam int DST_LSB  = 24;
	localparam int SRC1_MSB = 23;
	localparam int SRC1_LSB = 20;
	localparam int SRC2_MSB = 19;
	localparam int SRC2_LSB = 16;

	// only alu and load produce a register result
	function automatic logic op_writes_dst(op_t op);
		return (op == OP_ALU) || (op == OP_LOAD);
	endfunction

endpackage : uop_pkg

// File: hw/decode_stage.sv
/*
 * decode stage: slices opcode and register fields out of the
 * instruction word and holds the result in one valid/ready slot
 */

module decode_stage #(
	parameter int ARCH_REG_BITS = rename_cfg_pkg::ARCH_REG_BITS
) (
	input  logic                     clk,
	input  logic                     reset,
	// instruction word in
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [31:0]              in_instr,
	// decoded uop out
	output logic                     dec_valid,
	input  logic                     dec_ready,
	output uop_pkg::op_t             dec_opcode,
	output logic                     dec_writes,
	output logic [ARCH_REG_BITS-1:0] dec_dst,
	output logic [ARCH_REG_BITS-1:0] dec_src1,
	output logic [ARCH_REG_BITS-1:0] dec_src2
);

	import uop_pkg::*;

	op_t  opc_next;   // legalized opcode of the incoming word
	logic load_slot;  // slot takes a new word this edge

	// legal codes pass through, the rest collapse to nop
	always_comb begin
		case (in_instr[OPC_MSB:OPC_LSB])
			OP_ALU,
			OP_LOAD,
			OP_STORE,
			OP_BRANCH: opc_next = op_t'(in_instr[OPC_MSB:OPC_LSB]);
			default:   opc_next = OP_NOP;
		endcase
	end

	// slot is free when empty or being drained this cycle
	assign in_ready  = !dec_valid || dec_ready;
	assign load_slot = in_valid && in_ready;

	// valid bit, control state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (in_ready) begin
			dec_valid <= in_valid;  // refill or go empty
		end
	end

	// payload, only written on accept
	always_ff @(posedge clk) begin
		if (load_slot) begin
			dec_opcode <= opc_next;
			dec_writes <= op_writes_dst(opc_next);
			dec_dst    <= in_instr[DST_LSB +: ARCH_REG_BITS];
			dec_src1   <= in_instr[SRC1_LSB +: ARCH_REG_BITS];
			dec_src2   <= in_instr[SRC2_LSB +: ARCH_REG_BITS];
		end
	end

	// field widths in the word must cover the arch reg index
	initial begin
		if (ARCH_REG_BITS > DST_MSB - DST_LSB + 1 ||
				ARCH_REG_BITS > SRC1_MSB - SRC1_LSB + 1 ||
				ARCH_REG_BITS > SRC2_MSB - SRC2_LSB + 1) begin
			$error("decode_stage: ARCH_REG_BITS wider than instruction fields");
		end
	end

endmodule : decode_stage

// File: hw/free_list_fifo.sv
/*
 * free list of physical registers, circular FIFO with
 * first-word fall-through head and a reset preload
 */

module free_list_fifo #(
	parameter int PHYS_REG_BITS = rename_cfg_pkg::PHYS_REG_BITS,
	parameter int PRELOAD_START = rename_cfg_pkg::ARCH_REG_COUNT,
	parameter int PRELOAD_COUNT = rename_cfg_pkg::FREE_PRELOAD_COUNT
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     push,
	input  logic [PHYS_REG_BITS-1:0] push_reg,
	input  logic                     pop,
	output logic [PHYS_REG_BITS-1:0] head_reg,
	output logic                     empty
);

	localparam int DEPTH    = 1 << PHYS_REG_BITS;  // one slot per phys reg
	localparam int PTR_BITS = PHYS_REG_BITS;
	localparam int CNT_BITS = PHYS_REG_BITS + 1;   // must reach DEPTH

	logic [PHYS_REG_BITS-1:0] mem [DEPTH];
	logic [PTR_BITS-1:0]      rd_ptr;
	logic [PTR_BITS-1:0]      wr_ptr;
	logic [CNT_BITS-1:0]      count;
	logic                     full;
	logic                     do_push;
	logic                     do_pop;

	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	assign head_reg = mem[rd_ptr];  // fall-through, valid while !empty

	// ignore pop on empty and push on full
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// ascending preload, slots past PRELOAD_COUNT are don't-care
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= PHYS_REG_BITS'(PRELOAD_START + i);
			end
			rd_ptr <= '0;
			wr_ptr <= PTR_BITS'(PRELOAD_COUNT);  // wraps to 0 when completely full
			count  <= CNT_BITS'(PRELOAD_COUNT);
		end else begin
			if (do_push) begin
				mem[wr_ptr] <= push_reg;
				wr_ptr      <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// preload must fit in the buffer
	initial begin
		if (PRELOAD_COUNT > DEPTH) begin
			$error("free_list_fifo: PRELOAD_COUNT exceeds depth");
		end
	end

endmodule : free_list_fifo

// File: hw/rename_map.sv
/*
 * rename stage: speculative arch-to-phys map, superseded register
 * records per phys reg, allocation from and release to the free list
 */

module rename_map #(
	parameter int ARCH_REG_BITS = rename_cfg_pkg::ARCH_REG_BITS,
	parameter int PHYS_REG_BITS = rename_cfg_pkg::PHYS_REG_BITS
) (
	input  logic                     clk,
	input  logic                     reset,
	// decoded uop in
	input  logic                     dec_valid,
	output logic                     dec_ready,
	input  uop_pkg::op_t             dec_opcode,
	input  logic                     dec_writes,
	input  logic [ARCH_REG_BITS-1:0] dec_dst,
	input  logic [ARCH_REG_BITS-1:0] dec_src1,
	input  logic [ARCH_REG_BITS-1:0] dec_src2,
	// renamed uop out
	output logic                     ren_valid,
	input  logic                     ren_ready,
	output uop_pkg::op_t             ren_opcode,
	output logic                     ren_writes,
	output logic [PHYS_REG_BITS-1:0] ren_dst_phys,
	output logic [PHYS_REG_BITS-1:0] ren_src1_phys,
	output logic [PHYS_REG_BITS-1:0] ren_src2_phys,
	// retire side
	input  logic                     commit_valid,
	input  logic                     commit_with_write,
	input  logic [PHYS_REG_BITS-1:0] commit_phys
);

	localparam int ARCH_REGS = 1 << ARCH_REG_BITS;
	localparam int PHYS_REGS = 1 << PHYS_REG_BITS;

	logic [PHYS_REG_BITS-1:0] map_tbl [ARCH_REGS];   // arch -> current phys
	logic [PHYS_REG_BITS-1:0] prev_reg [PHYS_REGS];  // phys -> the one it replaced
	logic [PHYS_REGS-1:0]     prev_valid;            // prev_reg entry is live

	logic                     fl_empty;
	logic [PHYS_REG_BITS-1:0] fl_head;
	logic                     can_rename;
	logic                     fire;
	logic                     alloc;
	logic                     release_hit;

	free_list_fifo #(
		.PHYS_REG_BITS (PHYS_REG_BITS),
		.PRELOAD_START (ARCH_REGS),
		.PRELOAD_COUNT (PHYS_REGS - ARCH_REGS)
	) free_list_i (
		.clk      (clk),
		.reset    (reset),
		.push     (release_hit),
		.push_reg (prev_reg[commit_phys]),
		.pop      (alloc),
		.head_reg (fl_head),
		.empty    (fl_empty)
	);

	// writers need a free reg, everything else always goes
	assign can_rename = !dec_writes || !fl_empty;
	assign ren_valid  = dec_valid && can_rename;
	assign dec_ready  = ren_ready && can_rename;
	assign fire       = dec_valid && dec_ready;
	assign alloc      = fire && dec_writes;

	// retire only frees something if there is a recorded predecessor
	assign release_hit = commit_valid && commit_with_write && prev_valid[commit_phys];

	// data path straight through, sources see the map before this uop
	assign ren_opcode    = dec_opcode;
	assign ren_writes    = dec_writes;
	assign ren_dst_phys  = dec_writes ? fl_head : '0;
	assign ren_src1_phys = map_tbl[dec_src1];
	assign ren_src2_phys = map_tbl[dec_src2];

	// map table and record valid bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				map_tbl[i] <= PHYS_REG_BITS'(i);  // identity
			end
			prev_valid <= '0;
		end else begin
			if (release_hit) begin
				prev_valid[commit_phys] <= 1'b0;
			end
			// alloc after release, so a same-edge hit on one reg keeps the new record
			if (alloc) begin
				map_tbl[dec_dst]    <= fl_head;
				prev_valid[fl_head] <= 1'b1;
			end
		end
	end

	// superseded reg numbers, qualified by prev_valid
	always_ff @(posedge clk) begin
		if (alloc) begin
			prev_reg[fl_head] <= map_tbl[dec_dst];
		end
	end

endmodule : rename_map

// File: hw/rename_out_stage.sv
/*
 * output slot for renamed uops, holds under back-pressure
 */

module rename_out_stage #(
	parameter int PHYS_REG_BITS = rename_cfg_pkg::PHYS_REG_BITS
) (
	input  logic                     clk,
	input  logic                     reset,
	// from rename
	input  logic                     ren_valid,
	output logic                     ren_ready,
	input  uop_pkg::op_t             ren_opcode,
	input  logic                     ren_writes,
	input  logic [PHYS_REG_BITS-1:0] ren_dst_phys,
	input  logic [PHYS_REG_BITS-1:0] ren_src1_phys,
	input  logic [PHYS_REG_BITS-1:0] ren_src2_phys,
	// to consumer
	output logic                     out_valid,
	input  logic                     out_ready,
	output uop_pkg::op_t             out_opcode,
	output logic                     out_writes,
	output logic [PHYS_REG_BITS-1:0] out_dst_phys,
	output logic [PHYS_REG_BITS-1:0] out_src1_phys,
	output logic [PHYS_REG_BITS-1:0] out_src2_phys
);

	logic load_slot;

	assign ren_ready = !out_valid || out_ready;  // empty or draining
	assign load_slot = ren_valid && ren_ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (ren_ready) begin
			out_valid <= ren_valid;
		end
	end

	// data frozen while out_valid && !out_ready
	always_ff @(posedge clk) begin
		if (load_slot) begin
			out_opcode    <= ren_opcode;
			out_writes    <= ren_writes;
			out_dst_phys  <= ren_dst_phys;
			out_src1_phys <= ren_src1_phys;
			out_src2_phys <= ren_src2_phys;
		end
	end

endmodule : rename_out_stage

// File: hw/rename_unit_top.sv
/*
 * rename front end top: decode, rename and output stages
 * plus the commit port feeding register release
 */

module rename_unit_top #(
	parameter int ARCH_REG_BITS = rename_cfg_pkg::ARCH_REG_BITS,
	parameter int PHYS_REG_BITS = rename_cfg_pkg::PHYS_REG_BITS
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  logic [31:0]              in_instr,
	output logic                     out_valid,
	input  logic                     out_ready,
	output uop_pkg::op_t             out_opcode,
	output logic                     out_writes,
	output logic [PHYS_REG_BITS-1:0] out_dst_phys,
	output logic [PHYS_REG_BITS-1:0] out_src1_phys,
	output logic [PHYS_REG_BITS-1:0] out_src2_phys,
	input  logic                     commit_valid,       // always accepted
	input  logic                     commit_with_write,
	input  logic [PHYS_REG_BITS-1:0] commit_phys
);

	import uop_pkg::*;

	// decode -> rename
	logic                     dec_valid;
	logic                     dec_ready;
	op_t                      dec_opcode;
	logic                     dec_writes;
	logic [ARCH_REG_BITS-1:0] dec_dst;
	logic [ARCH_REG_BITS-1:0] dec_src1;
	logic [ARCH_REG_BITS-1:0] dec_src2;

	// rename -> output
	logic                     ren_valid;
	logic                     ren_ready;
	op_t                      ren_opcode;
	logic                     ren_writes;
	logic [PHYS_REG_BITS-1:0] ren_dst_phys;
	logic [PHYS_REG_BITS-1:0] ren_src1_phys;
	logic [PHYS_REG_BITS-1:0] ren_src2_phys;

	decode_stage #(.ARCH_REG_BITS(ARCH_REG_BITS)) decode_i (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.dec_valid(dec_valid), .dec_ready(dec_ready),
		.dec_opcode(dec_opcode), .dec_writes(dec_writes),
		.dec_dst(dec_dst), .dec_src1(dec_src1), .dec_src2(dec_src2)
	);

	rename_map #(.ARCH_REG_BITS(ARCH_REG_BITS), .PHYS_REG_BITS(PHYS_REG_BITS)) map_i (
		.clk(clk), .reset(reset),
		.dec_valid(dec_valid), .dec_ready(dec_ready),
		.dec_opcode(dec_opcode), .dec_writes(dec_writes),
		.dec_dst(dec_dst), .dec_src1(dec_src1), .dec_src2(dec_src2),
		.ren_valid(ren_valid), .ren_ready(ren_ready),
		.ren_opcode(ren_opcode), .ren_writes(ren_writes), .ren_dst_phys(ren_dst_phys),
		.ren_src1_phys(ren_src1_phys), .ren_src2_phys(ren_src2_phys),
		.commit_valid(commit_valid), .commit_with_write(commit_with_write),
		.commit_phys(commit_phys)
	);

	rename_out_stage #(.PHYS_REG_BITS(PHYS_REG_BITS)) out_i (
		.clk(clk), .reset(reset),
		.ren_valid(ren_valid), .ren_ready(ren_ready),
		.ren_opcode(ren_opcode), .ren_writes(ren_writes), .ren_dst_phys(ren_dst_phys),
		.ren_src1_phys(ren_src1_phys), .ren_src2_phys(ren_src2_phys),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_opcode(out_opcode), .out_writes(out_writes), .out_dst_phys(out_dst_phys),
		.out_src1_phys(out_src1_phys), .out_src2_phys(out_src2_phys)
	);

endmodule : rename_unit_top

// File: sim/rename_unit_checker.sv
/*
 * protocol assertions bound into rename_unit_top
 */

module rename_unit_checker #(
	parameter int PHYS_REG_BITS = rename_cfg_pkg::PHYS_REG_BITS
) (
	input logic                     clk,
	input logic                     reset,
	input logic                     dec_valid,
	input logic                     ren_valid,
	input logic                     out_valid,
	input logic                     out_ready,
	input uop_pkg::op_t             out_opcode,
	input logic                     out_writes,
	input logic [PHYS_REG_BITS-1:0] out_dst_phys,
	input logic [PHYS_REG_BITS-1:0] out_src1_phys,
	input logic [PHYS_REG_BITS-1:0] out_src2_phys
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;  // failed assertions so far

	// whole pipe empty on the edge after reset
	idle_out_of_reset: assert property (@(posedge clk)
		reset |=> !dec_valid && !ren_valid && !out_valid)
		else begin
			$error("a valid was high right after reset");
			fail_count++;
		end

	// uop and payload frozen while the consumer stalls
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_opcode) && $stable(out_writes)
			&& $stable(out_dst_phys) && $stable(out_src1_phys) && $stable(out_src2_phys))
		else begin
			$error("output changed under back-pressure");
			fail_count++;
		end

	dst_known: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> !$isunknown(out_dst_phys))
		else begin
			$error("out_dst_phys unknown while out_valid");
			fail_count++;
		end

endmodule : rename_unit_checker

// File: sim/rename_unit_tb.sv
/*
 * testbench for rename_unit_top: instruction stream, committing back end,
 * reference model of map table, superseded records and free list
 */

module rename_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rename_cfg_pkg::*;
	import uop_pkg::*;

	localparam int RANDOM_OPS = 300;
	localparam int TOTAL_OPS  = ARCH_REG_COUNT + 75 + RANDOM_OPS;

	logic clk, reset, in_valid, in_ready, out_valid, out_ready, out_writes;
	logic commit_valid, commit_with_write;
	logic [31:0] in_instr;
	op_t out_opcode;
	logic [PHYS_REG_BITS-1:0] out_dst_phys, out_src1_phys, out_src2_phys, commit_phys;

	logic [PHYS_REG_BITS-1:0] model_map [ARCH_REG_COUNT];
	logic [PHYS_REG_BITS-1:0] model_prev [PHYS_REG_COUNT];  // superseded reg per phys reg
	logic [PHYS_REG_COUNT-1:0] model_has_prev = '0;
	logic [PHYS_REG_BITS-1:0] free_q [$];    // head at index 0
	logic [PHYS_REG_BITS-1:0] retire_q [$];  // written regs seen, not yet committed
	logic [PHYS_REG_BITS-1:0] last_commit;
	logic [31:0] sent_q [$];                 // accepted words awaiting output
	int seed = 82;
	int seen = 0;
	int idle_cycles = 0;
	bit in_taken = 0;
	bit commit_on = 1;
	bit have_last = 0;

	rename_unit_top dut_i (.*);
	bind rename_unit_top rename_unit_checker #(.PHYS_REG_BITS(PHYS_REG_BITS)) checker_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (TOTAL_OPS * 40) @(posedge clk);  // 40 cycles per op
		stop_run("timeout: the DUT did not deliver every instruction");
	end

	// a failed protocol assertion ends the run at once
	always @(dut_i.checker_i.fail_count) begin
		if (dut_i.checker_i.fail_count != 0) begin
			stop_run("a protocol assertion of the checker failed");
		end
	end

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_eq(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else
			stop_run($sformatf("CHECK FAILED at %0t: %s expected %0d, actual %0d",
				$time, name, exp, act));
	endtask

	// one falling edge: consumer ready and back-end commits
	task automatic step();
		int pick;
		@(negedge clk);
		out_ready = ($random(seed) & 3) != 0;  // stall about one cycle in four
		pick = $random(seed) & 7;
		commit_valid = 1'b0;
		commit_with_write = 1'b1;
		if (pick < 3 && commit_on && retire_q.size() > 0) begin
			commit_valid = 1'b1;
			commit_phys = retire_q.pop_front();  // in-order retire
			last_commit = commit_phys;
			have_last = 1'b1;
		end else if (pick == 3 && retire_q.size() > 0) begin
			commit_valid = 1'b1;
			commit_with_write = 1'b0;  // retire without a write
			commit_phys = retire_q[0];
		end else if (pick == 4 && have_last) begin
			commit_valid = 1'b1;  // predecessor already returned
			commit_phys = last_commit;
		end
		// writers stuck with nothing free, let the back end retire again
		if (!commit_on && idle_cycles > 30) begin
			assert (free_q.size() == 0) else
				stop_run("rename stalled although the model still had free registers");
			commit_on = 1'b1;
		end
	endtask

	task automatic send(logic [3:0] opc, logic [3:0] dst, logic [3:0] s1, logic [3:0] s2);
		logic [31:0] w;
		w = $random(seed);  // filler in the low bits
		w[OPC_MSB:OPC_LSB] = opc;
		w[DST_MSB:DST_LSB] = dst;
		w[SRC1_MSB:SRC1_LSB] = s1;
		w[SRC2_MSB:SRC2_LSB] = s2;
		in_valid = 1'b0;
		while (($random(seed) & 7) == 0) step();  // input gap
		in_valid = 1'b1;
		in_instr = w;
		do step(); while (!in_taken);
	endtask

	task automatic check_output();
		logic [31:0] instr;
		op_t op;
		logic [ARCH_REG_BITS-1:0] dst;
		logic [PHYS_REG_BITS-1:0] new_reg;
		assert (sent_q.size() > 0) else stop_run("output uop without a matching input word");
		instr = sent_q.pop_front();
		op = (instr[OPC_MSB:OPC_LSB] inside {OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH}) ?
			op_t'(instr[OPC_MSB:OPC_LSB]) : OP_NOP;
		dst = instr[DST_LSB +: ARCH_REG_BITS];
		expect_eq("out_opcode", op, out_opcode);
		expect_eq("out_writes", op_writes_dst(op), out_writes);
		expect_eq("out_src1_phys", model_map[instr[SRC1_LSB +: ARCH_REG_BITS]], out_src1_phys);
		expect_eq("out_src2_phys", model_map[instr[SRC2_LSB +: ARCH_REG_BITS]], out_src2_phys);
		if (op_writes_dst(op)) begin
			new_reg = free_q.pop_front();
			expect_eq("out_dst_phys", new_reg, out_dst_phys);
			model_prev[new_reg] = model_map[dst];
			model_has_prev[new_reg] = 1'b1;
			model_map[dst] = new_reg;
			retire_q.push_back(new_reg);
		end
		seen++;
	endtask

	// model follows every handshake and commit on the rising edge
	always @(posedge clk) begin
		if (!reset) begin
			in_taken = in_valid && in_ready;
			if (in_taken) sent_q.push_back(in_instr);
			if (commit_valid && commit_with_write && model_has_prev[commit_phys]) begin
				free_q.push_back(model_prev[commit_phys]);
				model_has_prev[commit_phys] = 1'b0;
			end
			if (out_valid && out_ready) check_output();
			idle_cycles = (out_valid && out_ready) ? 0 : idle_cycles + 1;
		end
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b0;
		commit_valid = 1'b0;
		commit_with_write = 1'b0;
		commit_phys = '0;
		for (int a = 0; a < ARCH_REG_COUNT; a++) model_map[a] = PHYS_REG_BITS'(a);
		for (int i = 0; i < FREE_PRELOAD_COUNT; i++)
			free_q.push_back(PHYS_REG_BITS'(ARCH_REG_COUNT + i));
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// untouched arch regs read as themselves
		for (int i = 0; i < ARCH_REG_COUNT; i++)
			send(OP_STORE, 4'(i), 4'(i), 4'(ARCH_REG_COUNT - 1 - i));
		commit_on = 1'b0;  // run the free list dry
		for (int i = 0; i < 75; i++)
			send((i % 5 == 4) ? OP_STORE : OP_ALU,
				4'($random(seed)), 4'($random(seed)), 4'($random(seed)));
		commit_on = 1'b1;
		// mixed traffic, codes 5..7 illegal
		for (int i = 0; i < RANDOM_OPS; i++)
			send(4'($random(seed) & 7), 4'($random(seed)), 4'($random(seed)), 4'($random(seed)));
		in_valid = 1'b0;
		while (seen < TOTAL_OPS) step();
		repeat (10) step();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule : rename_unit_tb

// File: rename_unit_top.f
hw/rename_cfg_pkg.sv
hw/uop_pkg.sv
hw/decode_stage.sv
hw/free_list_fifo.sv
hw/rename_map.sv
hw/rename_out_stage.sv
hw/rename_unit_top.sv
sim/rename_unit_checker.sv
sim/rename_unit_tb.sv

// File: Bender.yml
package:
  name: rename_unit

sources:
  - hw/rename_cfg_pkg.sv
  - hw/uop_pkg.sv
  - hw/decode_stage.sv
  - hw/free_list_fifo.sv
  - hw/rename_map.sv
  - hw/rename_out_stage.sv
  - hw/rename_unit_top.sv
  - target: simulation
    files:
      - sim/rename_unit_checker.sv
      - sim/rename_unit_tb.sv
